/* project.f */
snake_pkg.sv
snake_apb_regs.sv
snake_fsm.sv
snake_step_timer.sv
snake_body.sv
snake_food.sv
snake_score.sv
snake_top.sv
tb_snake.sv

/* snake_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module snake_apb_regs (
	input  logic                               clk,
	input  logic                               arst_n,
	input  logic                               psel,
	input  logic                               penable,
	input  logic                               pwrite,
	input  logic [snake_pkg::ADDR_W-1:0]       paddr,
	input  logic [31:0]                        pwdata,
	output logic [31:0]                        prdata,
	output logic                               pready,
	output logic                               pslverr,
	input  snake_pkg::game_state_t             state,
	input  logic [snake_pkg::SCORE_W-1:0]      score,
	input  logic [snake_pkg::SCORE_W-1:0]      hiscore,
	input  logic [snake_pkg::LEN_W-1:0]        length,
	input  snake_pkg::cell_t                   head,
	input  snake_pkg::cell_t                   apple,
	input  logic [snake_pkg::STEP_W-1:0]       steps,
	output logic                               start,
	output snake_pkg::speed_t                  speed,
	output snake_pkg::dir_t                    dir_req
);

	logic access;
	logic mapped;
	logic writable;
	logic wr_en;
	logic idle_or_over;
	logic [31:0] rdata;

	assign pready = 1'b1;
	assign access = psel && penable;

	always_comb begin
		mapped = 1'b1;
		writable = 1'b0;
		case (paddr)
			snake_pkg::REG_CTRL,
			snake_pkg::REG_DIR:    writable = 1'b1;
			snake_pkg::REG_STATUS,
			snake_pkg::REG_SCORE,
			snake_pkg::REG_LENGTH,
			snake_pkg::REG_HEAD,
			snake_pkg::REG_APPLE,
			snake_pkg::REG_STEPS:  writable = 1'b0;
			default:               mapped = 1'b0;
		endcase
	end

	assign pslverr = access && (!mapped || (pwrite && !writable));
	assign wr_en = access && pwrite && mapped && writable;
	assign idle_or_over = (state == snake_pkg::ST_IDLE) || (state == snake_pkg::ST_OVER);

	// ####################
	// control writes
	// ####################
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			start <= 1'b0;
			speed <= '0;
			dir_req <= snake_pkg::DIR_NONE;
		end else begin
			start <= wr_en && (paddr == snake_pkg::REG_CTRL) && pwdata[0];
			// speed only changes between games
			if (wr_en && (paddr == snake_pkg::REG_CTRL) && pwdata[0] && idle_or_over)
				speed <= pwdata[2:1];
			// a new game waits for a fresh first direction
			if (state == snake_pkg::ST_INIT)
				dir_req <= snake_pkg::DIR_NONE;
			else if (wr_en && (paddr == snake_pkg::REG_DIR) && (pwdata[2:0] <= 3'd4))
				dir_req <= snake_pkg::dir_t'(pwdata[2:0]);
		end
	end

	// ####################
	// read mux
	// ####################
	always_comb begin
		rdata = '0;
		case (paddr)
			snake_pkg::REG_CTRL:   rdata[2:1] = speed;
			snake_pkg::REG_DIR:    rdata[2:0] = dir_req;
			snake_pkg::REG_STATUS: begin
				rdata[2:0] = state;
				rdata[3] = (state == snake_pkg::ST_OVER);
				rdata[4] = (state == snake_pkg::ST_RUN) || (state == snake_pkg::ST_MOVE) ||
					(state == snake_pkg::ST_JUDGE);
			end
			snake_pkg::REG_SCORE:  rdata = {hiscore, score};
			snake_pkg::REG_LENGTH: rdata[snake_pkg::LEN_W-1:0] = length;
			snake_pkg::REG_HEAD: begin
				rdata[snake_pkg::X_W-1:0] = head.x;
				rdata[16 +: snake_pkg::Y_W] = head.y;
			end
			snake_pkg::REG_APPLE: begin
				rdata[snake_pkg::X_W-1:0] = apple.x;
				rdata[16 +: snake_pkg::Y_W] = apple.y;
			end
			snake_pkg::REG_STEPS:  rdata[snake_pkg::STEP_W-1:0] = steps;
			default:               rdata = '0;
		endcase
	end

	// data only shows during a read access cycle
	assign prdata = (access && !pwrite) ? rdata : '0;

endmodule

`default_nettype wire

/* snake_body.sv */
`timescale 1ns/1ps
`default_nettype none

module snake_body #(
	parameter int GRID_W  = 16,
	parameter int GRID_H  = 12,
	parameter int MAX_LEN = 32
) (
	input  logic                        clk,
	input  logic                        arst_n,
	input  snake_pkg::game_ctrl_t       ctrl,
	input  snake_pkg::dir_t             dir_req,
	input  logic                        eaten,
	output snake_pkg::cell_t            head,
	output logic [snake_pkg::LEN_W-1:0] length,
	output logic                        wall_hit,
	output logic                        self_hit,
	output logic                        scan_done
);

	localparam logic [snake_pkg::X_W-1:0] X_LAST = snake_pkg::X_W'(GRID_W - 1);
	localparam logic [snake_pkg::Y_W-1:0] Y_LAST = snake_pkg::Y_W'(GRID_H - 1);

	// body segments behind the head, seg[1] is the neck
	snake_pkg::cell_t seg [1:MAX_LEN-1];
	snake_pkg::dir_t heading;
	snake_pkg::dir_t new_dir;
	snake_pkg::cell_t next_head;
	logic leave_grid;
	logic scanning;
	logic [snake_pkg::LEN_W-1:0] scan_idx;

	function automatic logic is_reverse(snake_pkg::dir_t a, snake_pkg::dir_t b);
		return ((a == snake_pkg::DIR_UP) && (b == snake_pkg::DIR_DOWN)) ||
			((a == snake_pkg::DIR_DOWN) && (b == snake_pkg::DIR_UP)) ||
			((a == snake_pkg::DIR_LEFT) && (b == snake_pkg::DIR_RIGHT)) ||
			((a == snake_pkg::DIR_RIGHT) && (b == snake_pkg::DIR_LEFT));
	endfunction

	// reversals and empty requests keep the old heading
	always_comb begin
		new_dir = heading;
		if ((dir_req != snake_pkg::DIR_NONE) && !is_reverse(dir_req, heading))
			new_dir = dir_req;
	end

	always_comb begin
		next_head = head;
		leave_grid = 1'b0;
		case (new_dir)
			snake_pkg::DIR_UP: begin
				leave_grid = (head.y == '0);
				next_head.y = head.y - 1'b1;
			end
			snake_pkg::DIR_DOWN: begin
				leave_grid = (head.y == Y_LAST);
				next_head.y = head.y + 1'b1;
			end
			snake_pkg::DIR_LEFT: begin
				leave_grid = (head.x == '0);
				next_head.x = head.x - 1'b1;
			end
			snake_pkg::DIR_RIGHT: begin
				leave_grid = (head.x == X_LAST);
				next_head.x = head.x + 1'b1;
			end
			default: ;
		endcase
	end

	// ####################
	// head, heading, length
	// ####################
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			head <= '0;
			heading <= snake_pkg::DIR_NONE;
			length <= '0;
			wall_hit <= 1'b0;
		end else if (ctrl.init) begin
			head <= snake_pkg::START_CELL;
			heading <= snake_pkg::DIR_NONE;
			length <= snake_pkg::LEN_W'(1);
			wall_hit <= 1'b0;
		end else begin
			if (ctrl.move) begin
				heading <= new_dir;
				if (leave_grid)
					wall_hit <= 1'b1;
				else
					head <= next_head;
			end
			if (eaten && (length < MAX_LEN))
				length <= length + 1'b1;
		end
	end

	// shift register of segments, growth just exposes the old tail
	always_ff @(posedge clk) begin
		if (ctrl.move && !leave_grid) begin
			seg[1] <= head;
			for (int i = 2; i < MAX_LEN; i++)
				seg[i] <= seg[i-1];
		end
	end

	// ####################
	// self-collision scan
	// ####################
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			scanning <= 1'b0;
			scan_idx <= '0;
			self_hit <= 1'b0;
			scan_done <= 1'b0;
		end else if (ctrl.init) begin
			scanning <= 1'b0;
			scan_idx <= '0;
			self_hit <= 1'b0;
			scan_done <= 1'b0;
		end else if (ctrl.judge) begin
			scanning <= 1'b1;
			scan_idx <= snake_pkg::LEN_W'(1);
			self_hit <= 1'b0;
			scan_done <= 1'b0;
		end else if (scanning) begin
			// one segment per cycle, a wall hit needs no scan
			if ((scan_idx >= length) || wall_hit) begin
				scanning <= 1'b0;
				scan_done <= 1'b1;
			end else begin
				if (seg[scan_idx] == head)
					self_hit <= 1'b1;
				scan_idx <= scan_idx + 1'b1;
			end
		end else begin
			scan_done <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* snake_food.sv */
`timescale 1ns/1ps
`default_nettype none

module snake_food #(
	parameter int GRID_W = 16,
	parameter int GRID_H = 12
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  snake_pkg::game_ctrl_t ctrl,
	input  snake_pkg::cell_t      head,
	output snake_pkg::cell_t      apple,
	output logic                  eaten
);

	localparam int STRIDE_X = int'(snake_pkg::CAND_STRIDE.x) % GRID_W;
	localparam int STRIDE_Y = int'(snake_pkg::CAND_STRIDE.y) % GRID_H;

	snake_pkg::cell_t cand;
	snake_pkg::cell_t cand_next;

	// stride is already below size, so one subtract wraps it
	function automatic int wrap_add(int value, int stride, int size);
		int sum;
		sum = value + stride;
		if (sum >= size)
			sum = sum - size;
		return sum;
	endfunction

	assign cand_next.x = snake_pkg::X_W'(wrap_add(int'(cand.x), STRIDE_X, GRID_W));
	assign cand_next.y = snake_pkg::Y_W'(wrap_add(int'(cand.y), STRIDE_Y, GRID_H));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			apple <= snake_pkg::APPLE_INIT;
			cand <= snake_pkg::CAND_INIT;
			eaten <= 1'b0;
		end else if (ctrl.init) begin
			apple <= snake_pkg::APPLE_INIT;
			cand <= snake_pkg::CAND_INIT;
			eaten <= 1'b0;
		end else begin
			eaten <= ctrl.judge && (head == apple);
			if (ctrl.move)
				cand <= cand_next;
			// apple may land on the body
			if (eaten)
				apple <= cand;
		end
	end

endmodule

`default_nettype wire

/* snake_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module snake_fsm (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   start,
	input  snake_pkg::dir_t        dir_req,
	input  logic                   step_tick,
	input  logic                   wall_hit,
	input  logic                   self_hit,
	input  logic                   scan_done,
	output snake_pkg::game_state_t state,
	output snake_pkg::game_ctrl_t  ctrl
);

	snake_pkg::game_state_t next_state;

	always_comb begin
		next_state = state;
		case (state)
			snake_pkg::ST_IDLE,
			snake_pkg::ST_OVER: begin
				if (start)
					next_state = snake_pkg::ST_INIT;
			end
			snake_pkg::ST_INIT:
				next_state = snake_pkg::ST_WAIT_DIR;
			snake_pkg::ST_WAIT_DIR: begin
				if (dir_req != snake_pkg::DIR_NONE)
					next_state = snake_pkg::ST_RUN;
			end
			snake_pkg::ST_RUN: begin
				if (step_tick)
					next_state = snake_pkg::ST_MOVE;
			end
			snake_pkg::ST_MOVE:
				next_state = snake_pkg::ST_JUDGE;
			snake_pkg::ST_JUDGE: begin
				// stay until the body scan has finished
				if (scan_done)
					next_state = (wall_hit || self_hit) ? snake_pkg::ST_OVER : snake_pkg::ST_RUN;
			end
			default:
				next_state = snake_pkg::ST_IDLE;
		endcase
	end

	// ctrl is registered alongside the state so both change on the same edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= snake_pkg::ST_IDLE;
			ctrl <= '0;
		end else begin
			state <= next_state;
			ctrl.init <= (next_state == snake_pkg::ST_INIT);
			ctrl.move <= (next_state == snake_pkg::ST_MOVE);
			// first judge cycle only
			ctrl.judge <= (next_state == snake_pkg::ST_JUDGE) && (state != snake_pkg::ST_JUDGE);
			ctrl.running <= (next_state == snake_pkg::ST_RUN);
		end
	end

endmodule

`default_nettype wire

/* snake_pkg.sv */
`default_nettype none

package snake_pkg;

	// #####################
	// grid and field widths
	// #####################
	localparam int X_W     = 5;
	localparam int Y_W     = 5;
	localparam int LEN_W   = 8;
	localparam int SCORE_W = 16;
	localparam int STEP_W  = 16;
	localparam int ADDR_W  = 8;

	typedef struct packed {
		logic [X_W-1:0] x;
		logic [Y_W-1:0] y;
	} cell_t;

	typedef enum logic [2:0] {
		DIR_NONE  = 3'd0,
		DIR_UP    = 3'd1,
		DIR_LEFT  = 3'd2,
		DIR_DOWN  = 3'd3,
		DIR_RIGHT = 3'd4
	} dir_t;

	// 0 slow, 1 medium, 2 fast
	typedef logic [1:0] speed_t;

	// step period in timer units, indexed by speed
	localparam int unsigned STEP_UNITS [0:2] = '{4, 2, 1};

	typedef struct packed {
		logic init;
		logic move;
		logic judge;
		logic running;
	} game_ctrl_t;

	typedef enum logic [2:0] {
		ST_IDLE     = 3'd0,
		ST_INIT     = 3'd1,
		ST_WAIT_DIR = 3'd2,
		ST_RUN      = 3'd3,
		ST_MOVE     = 3'd4,
		ST_JUDGE    = 3'd5,
		ST_OVER     = 3'd6
	} game_state_t;

	// #####################
	// register map
	// #####################
	localparam logic [ADDR_W-1:0] REG_CTRL   = 8'h00;
	localparam logic [ADDR_W-1:0] REG_DIR    = 8'h04;
	localparam logic [ADDR_W-1:0] REG_STATUS = 8'h08;
	localparam logic [ADDR_W-1:0] REG_SCORE  = 8'h0C;
	localparam logic [ADDR_W-1:0] REG_LENGTH = 8'h10;
	localparam logic [ADDR_W-1:0] REG_HEAD   = 8'h14;
	localparam logic [ADDR_W-1:0] REG_APPLE  = 8'h18;
	localparam logic [ADDR_W-1:0] REG_STEPS  = 8'h1C;

	// fixed cells, stride is wrapped by the grid size where it is used
	localparam cell_t START_CELL  = '{x: X_W'(2), y: Y_W'(2)};
	localparam cell_t APPLE_INIT  = '{x: X_W'(5), y: Y_W'(2)};
	localparam cell_t CAND_INIT   = '{x: X_W'(1), y: Y_W'(1)};
	localparam cell_t CAND_STRIDE = '{x: X_W'(7), y: Y_W'(5)};

endpackage

`default_nettype wire

/* snake_score.sv */
`timescale 1ns/1ps
`default_nettype none

module snake_score (
	input  logic                          clk,
	input  logic                          arst_n,
	input  snake_pkg::game_ctrl_t         ctrl,
	input  logic                          eaten,
	output logic [snake_pkg::SCORE_W-1:0] score,
	output logic [snake_pkg::SCORE_W-1:0] hiscore
);

	logic [snake_pkg::SCORE_W-1:0] score_inc;

	assign score_inc = score + 1'b1;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			score <= '0;
			hiscore <= '0;
		end else if (ctrl.init) begin
			// hiscore carries over to the next game
			score <= '0;
		end else if (eaten) begin
			score <= score_inc;
			if (score_inc > hiscore)
				hiscore <= score_inc;
		end
	end

endmodule

`default_nettype wire

/* snake_step_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module snake_step_timer #(
	parameter int TICK_DIV = 4
) (
	input  logic                         clk,
	input  logic                         arst_n,
	input  snake_pkg::game_ctrl_t        ctrl,
	input  snake_pkg::speed_t            speed,
	output logic                         step_tick,
	output logic [snake_pkg::STEP_W-1:0] steps
);

	localparam int PRE_W = $clog2(TICK_DIV + 1);

	logic [PRE_W-1:0] pre_cnt;
	logic [2:0] unit_cnt;
	logic [2:0] unit_last;
	logic pre_wrap;

	// speed code 3 runs as fast
	assign unit_last = 3'(snake_pkg::STEP_UNITS[(speed > 2'd2) ? 2'd2 : speed] - 1);
	assign pre_wrap = (pre_cnt == PRE_W'(TICK_DIV - 1));
	assign step_tick = ctrl.running && pre_wrap && (unit_cnt == unit_last);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pre_cnt <= '0;
			unit_cnt <= '0;
		end else if (!ctrl.running) begin
			// restart from zero on every entry to run
			pre_cnt <= '0;
			unit_cnt <= '0;
		end else if (pre_wrap) begin
			pre_cnt <= '0;
			unit_cnt <= (unit_cnt == unit_last) ? 3'd0 : unit_cnt + 3'd1;
		end else begin
			pre_cnt <= pre_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			steps <= '0;
		else if (ctrl.init)
			steps <= '0;
		else if (ctrl.move)
			steps <= steps + 1'b1;
	end

endmodule

`default_nettype wire

/* snake_top.sv */
`timescale 1ns/1ps
`default_nettype none

module snake_top #(
	parameter int GRID_W   = 16,
	parameter int GRID_H   = 12,
	parameter int MAX_LEN  = 32,
	parameter int TICK_DIV = 4
) (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  logic [snake_pkg::ADDR_W-1:0] paddr,
	input  logic [31:0]                  pwdata,
	output logic [31:0]                  prdata,
	output logic                         pready,
	output logic                         pslverr
);

	snake_pkg::game_state_t state;
	snake_pkg::game_ctrl_t ctrl;
	snake_pkg::speed_t speed;
	snake_pkg::dir_t dir_req;
	snake_pkg::cell_t head;
	snake_pkg::cell_t apple;
	logic start;
	logic step_tick;
	logic wall_hit;
	logic self_hit;
	logic scan_done;
	logic eaten;
	logic [snake_pkg::STEP_W-1:0] steps;
	logic [snake_pkg::LEN_W-1:0] length;
	logic [snake_pkg::SCORE_W-1:0] score;
	logic [snake_pkg::SCORE_W-1:0] hiscore;

	// host side
	snake_apb_regs i_regs (
		.clk(clk), .arst_n(arst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.state(state), .score(score), .hiscore(hiscore), .length(length),
		.head(head), .apple(apple), .steps(steps),
		.start(start), .speed(speed), .dir_req(dir_req)
	);

	snake_fsm i_fsm (
		.clk(clk), .arst_n(arst_n),
		.start(start), .dir_req(dir_req), .step_tick(step_tick),
		.wall_hit(wall_hit), .self_hit(self_hit), .scan_done(scan_done),
		.state(state), .ctrl(ctrl)
	);

	snake_step_timer #(.TICK_DIV(TICK_DIV)) i_timer (
		.clk(clk), .arst_n(arst_n),
		.ctrl(ctrl), .speed(speed), .step_tick(step_tick), .steps(steps)
	);

	// game data
	snake_body #(.GRID_W(GRID_W), .GRID_H(GRID_H), .MAX_LEN(MAX_LEN)) i_body (
		.clk(clk), .arst_n(arst_n),
		.ctrl(ctrl), .dir_req(dir_req), .eaten(eaten),
		.head(head), .length(length), .wall_hit(wall_hit), .self_hit(self_hit),
		.scan_done(scan_done)
	);

	snake_food #(.GRID_W(GRID_W), .GRID_H(GRID_H)) i_food (
		.clk(clk), .arst_n(arst_n),
		.ctrl(ctrl), .head(head), .apple(apple), .eaten(eaten)
	);

	snake_score i_score (
		.clk(clk), .arst_n(arst_n),
		.ctrl(ctrl), .eaten(eaten), .score(score), .hiscore(hiscore)
	);

endmodule

`default_nettype wire

/* tb_snake.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_snake;

	localparam int GRID_W = 10;
	localparam int GRID_H = 8;
	localparam int MAX_LEN = 16;
	localparam int TICK_DIV = 8;
	localparam int NUM_GAMES = 3;
	localparam int FREE_STEPS = 80;
	// slowest step is four units of run, one move cycle and a full scan
	localparam longint STEP_NS = (4 * TICK_DIV + MAX_LEN + 8) * 10;
	localparam longint TIMEOUT_NS =
		2 * NUM_GAMES * (FREE_STEPS + GRID_W + GRID_H + 20) * STEP_NS + 50000;

	localparam int D_UP = int'(snake_pkg::DIR_UP);
	localparam int D_LEFT = int'(snake_pkg::DIR_LEFT);
	localparam int D_DOWN = int'(snake_pkg::DIR_DOWN);
	localparam int D_RIGHT = int'(snake_pkg::DIR_RIGHT);
	localparam logic [31:0] STAT_WAIT = 32'(snake_pkg::ST_WAIT_DIR);
	localparam logic [31:0] STAT_RUN = 32'(snake_pkg::ST_RUN) | 32'h10;
	localparam logic [31:0] STAT_OVER = 32'(snake_pkg::ST_OVER) | 32'h08;

	logic clk;
	logic arst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	// game model with the head at index 0
	int seg_x [MAX_LEN];
	int seg_y [MAX_LEN];
	int m_len;
	int m_heading;
	int apple_x;
	int apple_y;
	int cand_x;
	int cand_y;
	int m_score;
	int m_hiscore;
	int m_steps;
	bit m_over;
	int m_speed;
	int coil_sense;

	snake_top #(
		.GRID_W(GRID_W), .GRID_H(GRID_H), .MAX_LEN(MAX_LEN), .TICK_DIV(TICK_DIV)
	) i_dut (
		.clk(clk), .arst_n(arst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the games did not finish within %0d ns", TIMEOUT_NS);
		$display("Done: errors found");
		$fatal(1, "watchdog expired");
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0d ns: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
			$display("Done: errors found");
			$fatal(1, "value mismatch");
		end
	endtask

	// ####################
	// APB access
	// ####################
	// called 1 ns after a rising edge and returns 1 ns after the access edge
	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		#1;
		rdata = prdata;
		err = pslverr;
		check_value("pready in access cycle", 32'(pready), 32'h1);
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] rdata);
		logic err;
		apb_access(1'b0, addr, 32'h0, rdata, err);
		check_value("pslverr on read", 32'(err), 32'h0);
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] wdata);
		logic [31:0] unused;
		logic err;
		apb_access(1'b1, addr, wdata, unused, err);
		check_value("pslverr on write", 32'(err), 32'h0);
	endtask

	// ####################
	// model helpers
	// ####################
	function automatic int step_dx(int d);
		return (d == D_RIGHT) ? 1 : ((d == D_LEFT) ? -1 : 0);
	endfunction

	function automatic int step_dy(int d);
		return (d == D_DOWN) ? 1 : ((d == D_UP) ? -1 : 0);
	endfunction

	function automatic bit on_grid(int x, int y);
		return (x >= 0) && (x < GRID_W) && (y >= 0) && (y < GRID_H);
	endfunction

	// up/down and left/right pair up in the code order
	function automatic int opposite(int d);
		return (d == 0) ? 0 : ((d + 1) % 4) + 1;
	endfunction

	// sense 1 turns clockwise and -1 counter-clockwise
	function automatic int rotate(int d, int sense);
		if (sense > 0)
			return (d == D_UP) ? D_RIGHT : d - 1;
		return (d == D_RIGHT) ? D_UP : d + 1;
	endfunction

	function automatic logic [31:0] cell_word(int x, int y);
		return (32'(y) << 16) | 32'(x);
	endfunction

	task automatic model_init();
		seg_x[0] = int'(snake_pkg::START_CELL.x);
		seg_y[0] = int'(snake_pkg::START_CELL.y);
		apple_x = int'(snake_pkg::APPLE_INIT.x);
		apple_y = int'(snake_pkg::APPLE_INIT.y);
		cand_x = int'(snake_pkg::CAND_INIT.x);
		cand_y = int'(snake_pkg::CAND_INIT.y);
		m_len = 1;
		m_heading = 0;
		m_score = 0;
		m_steps = 0;
		m_over = 1'b0;
	endtask

	task automatic model_step(input int d);
		int nx;
		int ny;
		int i;
		bit wall;
		bit bite;
		if ((d != 0) && (d != opposite(m_heading)))
			m_heading = d;
		nx = seg_x[0] + step_dx(m_heading);
		ny = seg_y[0] + step_dy(m_heading);
		wall = !on_grid(nx, ny);
		cand_x = (cand_x + int'(snake_pkg::CAND_STRIDE.x)) % GRID_W;
		cand_y = (cand_y + int'(snake_pkg::CAND_STRIDE.y)) % GRID_H;
		m_steps++;
		// the head stays put on a wall hit
		if (!wall) begin
			for (i = MAX_LEN - 1; i > 0; i--) begin
				seg_x[i] = seg_x[i-1];
				seg_y[i] = seg_y[i-1];
			end
			seg_x[0] = nx;
			seg_y[0] = ny;
		end
		if ((seg_x[0] == apple_x) && (seg_y[0] == apple_y)) begin
			if (m_len < MAX_LEN)
				m_len++;
			m_score++;
			if (m_score > m_hiscore)
				m_hiscore = m_score;
			apple_x = cand_x;
			apple_y = cand_y;
		end
		bite = 1'b0;
		for (i = 1; i < m_len; i++)
			if (!wall && (seg_x[i] == seg_x[0]) && (seg_y[i] == seg_y[0]))
				bite = 1'b1;
		m_over = wall || bite;
	endtask

	// ####################
	// steering
	// ####################
	function automatic int greedy_dir();
		int want_x;
		int want_y;
		want_x = (apple_x > seg_x[0]) ? D_RIGHT : ((apple_x < seg_x[0]) ? D_LEFT : 0);
		want_y = (apple_y > seg_y[0]) ? D_DOWN : ((apple_y < seg_y[0]) ? D_UP : 0);
		if ((want_x != 0) && (want_x != opposite(m_heading)))
			return want_x;
		if ((want_y != 0) && (want_y != opposite(m_heading)))
			return want_y;
		// go round an apple straight behind
		if (want_x != 0)
			return (seg_y[0] < GRID_H - 1) ? D_DOWN : D_UP;
		if (want_y != 0)
			return (seg_x[0] < GRID_W - 1) ? D_RIGHT : D_LEFT;
		return (m_heading == 0) ? D_RIGHT : m_heading;
	endfunction

	// tight 2x2 loop where the fourth turn bites segment 4
	function automatic int coil_dir();
		int d1;
		int d2;
		if (coil_sense == 0) begin
			d1 = rotate(m_heading, 1);
			d2 = rotate(d1, 1);
			coil_sense = on_grid(seg_x[0] + step_dx(d1) + step_dx(d2),
				seg_y[0] + step_dy(d1) + step_dy(d2)) ? 1 : -1;
		end
		return rotate(m_heading, coil_sense);
	endfunction

	// ####################
	// game sequences
	// ####################
	task automatic start_game(input int spd);
		logic [31:0] rd;
		write_reg(snake_pkg::REG_CTRL, (32'(spd) << 1) | 32'h1);
		m_speed = spd;
		model_init();
		read_reg(snake_pkg::REG_STATUS, rd);
		while (rd != STAT_WAIT)
			read_reg(snake_pkg::REG_STATUS, rd);
		read_reg(snake_pkg::REG_CTRL, rd);
		check_value("CTRL speed", rd, 32'(spd) << 1);
		check_full("after start");
	endtask

	task automatic check_full(input string tag);
		logic [31:0] rd;
		read_reg(snake_pkg::REG_HEAD, rd);
		check_value({"HEAD ", tag}, rd, cell_word(seg_x[0], seg_y[0]));
		read_reg(snake_pkg::REG_LENGTH, rd);
		check_value({"LENGTH ", tag}, rd, 32'(m_len));
		read_reg(snake_pkg::REG_SCORE, rd);
		check_value({"SCORE ", tag}, rd, (32'(m_hiscore) << 16) | 32'(m_score));
		read_reg(snake_pkg::REG_APPLE, rd);
		check_value({"APPLE ", tag}, rd, cell_word(apple_x, apple_y));
		read_reg(snake_pkg::REG_STEPS, rd);
		check_value({"STEPS ", tag}, rd, 32'(m_steps));
	endtask

	// mode 0 steers at random toward the apple and mode 1 grows and then coils
	task automatic play_game(input int mode);
		logic [31:0] rd;
		int step_no;
		int d;
		int prev_steps;
		coil_sense = 0;
		for (step_no = 0; !m_over; step_no++) begin
			if (step_no >= FREE_STEPS)
				d = m_heading;
			else if ((mode == 1) && (m_len >= 5))
				d = coil_dir();
			else if ((mode == 1) || ($urandom_range(0, 3) != 0))
				d = greedy_dir();
			else
				d = $urandom_range(1, 4);
			write_reg(snake_pkg::REG_DIR, 32'(d));
			prev_steps = m_steps;
			model_step(d);
			read_reg(snake_pkg::REG_STEPS, rd);
			while (rd == 32'(prev_steps))
				read_reg(snake_pkg::REG_STEPS, rd);
			read_reg(snake_pkg::REG_STATUS, rd);
			while ((rd[2:0] != 3'(snake_pkg::ST_RUN)) && (rd[2:0] != 3'(snake_pkg::ST_OVER)))
				read_reg(snake_pkg::REG_STATUS, rd);
			check_value("STATUS after step", rd, m_over ? STAT_OVER : STAT_RUN);
			// fast speed leaves time for one read before the next move
			if ((m_speed == 2) && !m_over) begin
				read_reg(snake_pkg::REG_HEAD, rd);
				check_value("HEAD after step", rd, cell_word(seg_x[0], seg_y[0]));
			end else begin
				check_full("after step");
			end
		end
	endtask

	task automatic check_over_hold();
		logic [31:0] rd;
		repeat (8 * TICK_DIV) @(posedge clk);
		#1;
		check_full("held in over");
		read_reg(snake_pkg::REG_STATUS, rd);
		check_value("STATUS held in over", rd, STAT_OVER);
	endtask

	initial begin
		int seed;
		int game;
		logic [31:0] rd;
		logic err;
		seed = $urandom(50812);
		arst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		m_hiscore = 0;
		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// idle state after reset
		read_reg(snake_pkg::REG_STATUS, rd);
		check_value("STATUS after reset", rd, 32'h0);
		read_reg(snake_pkg::REG_SCORE, rd);
		check_value("SCORE after reset", rd, 32'h0);
		read_reg(snake_pkg::REG_LENGTH, rd);
		check_value("LENGTH after reset", rd, 32'h0);
		read_reg(snake_pkg::REG_STEPS, rd);
		check_value("STEPS after reset", rd, 32'h0);
		apb_access(1'b0, 8'h20, 32'h0, rd, err);
		check_value("pslverr on unmapped read", 32'(err), 32'h1);
		apb_access(1'b1, snake_pkg::REG_STATUS, 32'h1, rd, err);
		check_value("pslverr on STATUS write", 32'(err), 32'h1);

		for (game = 0; game < NUM_GAMES; game++) begin
			start_game($urandom_range(0, 2));
			play_game((game == 1) ? 1 : 0);
			check_over_hold();
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire
